// ==== compile.f ====
src/cpu_pkg.sv
src/pc_counter.sv
src/inst_decoder.sv
src/reg_file.sv
src/exec_unit.sv
src/mem_access_ctrl.sv
src/cpu_core.sv
bench/cpu_assertions.sv
bench/tb_cpu_core.sv

// ==== Bender.yml ====
package:
  name: cpu_core

sources:
  - src/cpu_pkg.sv
  - src/pc_counter.sv
  - src/inst_decoder.sv
  - src/reg_file.sv
  - src/exec_unit.sv
  - src/mem_access_ctrl.sv
  - src/cpu_core.sv
  - target: simulation
    files:
      - bench/cpu_assertions.sv
      - bench/tb_cpu_core.sv

// ==== bench/tb_cpu_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module tb_cpu_core;
    import cpu_pkg::*;

    localparam word_t RESET_PC    = 32'h1C00_0000;
    localparam int    NUM_TESTS   = 20;
    localparam int    CYCLE_LIMIT = NUM_TESTS * 10 + 20;

    localparam logic [16:0] ADD_W  = 17'h00020;
    localparam logic [16:0] SUB_W  = 17'h00022;
    localparam logic [16:0] SLT    = 17'h00024;
    localparam logic [16:0] AND_OP = 17'h00029;
    localparam logic [16:0] OR_OP  = 17'h0002A;
    localparam logic [16:0] XOR_OP = 17'h0002B;
    localparam logic [9:0]  ADDI_W = 10'h00A;
    localparam logic [9:0]  LD_W   = 10'h0A2;
    localparam logic [9:0]  ST_W   = 10'h0A6;

    typedef struct packed {
        word_t     inst;
        logic      is_mem;
        reg_addr_t rd;
        word_t     value;    // Write-back value, or the store data
        logic      we;
        word_t     addr;    // Expected daccess_addr
    } test_t;

    logic       cpu_clk, cpu_rstn, ex_flag, ex_finish;
    word_t      ex_inst, daccess_addr, daccess_wdata, daccess_rdata;
    logic [3:0] daccess_ren, daccess_wen, debug_wb_ena;
    logic       daccess_valid, daccess_wresp, debug_wb_valid;
    word_t      debug_wb_pc, debug_wb_value;
    reg_addr_t  debug_wb_reg;

    test_t tests [NUM_TESTS];
    int    idx_q [$];
    word_t pc_q [$];
    word_t mem [64];
    word_t exp_addr, exp_wdata;
    int    seed = 58271;
    int    issued = 0, retired = 0, pass_count = 0, fail_count = 0;
    int    mem_errs = 0, cycles = 0, finish_count = 0;

    cpu_core #(.RESET_PC(RESET_PC)) dut (.*);

    function automatic word_t three_reg(input logic [16:0] op, input reg_addr_t rk,
                                        input reg_addr_t rj, input reg_addr_t rd);
        return {op, rk, rj, rd};
    endfunction

    function automatic word_t reg_imm12(input logic [9:0] op, input logic [11:0] si12,
                                        input reg_addr_t rj, input reg_addr_t rd);
        return {op, si12, rj, rd};
    endfunction

    function automatic word_t upper_imm20(input logic [19:0] si20, input reg_addr_t rd);
        return {7'h0A, si20, rd};    // lu12i.w
    endfunction

    task automatic set_entry(input int n, input word_t inst, input logic is_mem,
                             input reg_addr_t rd, input word_t value, input logic we,
                             input word_t addr);
        tests[n] = '{inst, is_mem, rd, value, we, addr};
    endtask

    task automatic load_table();
        set_entry(0,  upper_imm20(20'h12345, 1), 1'b0, 1, 32'h1234_5000, 1'b1, 0);
        set_entry(1,  reg_imm12(ADDI_W, 12'h678, 1, 1), 1'b0, 1, 32'h1234_5678, 1'b1, 0);
        set_entry(2,  reg_imm12(ADDI_W, 12'hFFF, 0, 2), 1'b0, 2, 32'hFFFF_FFFF, 1'b1, 0);
        set_entry(3,  three_reg(ADD_W, 2, 1, 3), 1'b0, 3, 32'h1234_5677, 1'b1, 0);
        set_entry(4,  three_reg(SUB_W, 1, 3, 4), 1'b0, 4, 32'hFFFF_FFFF, 1'b1, 0);
        set_entry(5,  three_reg(SLT, 0, 4, 5), 1'b0, 5, 32'h1, 1'b1, 0);    // -1 < 0
        set_entry(6,  three_reg(SLT, 4, 0, 6), 1'b0, 6, 32'h0, 1'b1, 0);
        set_entry(7,  three_reg(AND_OP, 2, 1, 7), 1'b0, 7, 32'h1234_5678, 1'b1, 0);
        set_entry(8,  three_reg(OR_OP, 3, 5, 8), 1'b0, 8, 32'h1234_5677, 1'b1, 0);
        set_entry(9,  three_reg(XOR_OP, 1, 8, 9), 1'b0, 9, 32'h0000_000F, 1'b1, 0);
        set_entry(10, reg_imm12(ADDI_W, 12'h005, 9, 0), 1'b0, 0, 32'h14, 1'b1, 0);
        set_entry(11, three_reg(ADD_W, 9, 0, 10), 1'b0, 10, 32'h0000_000F, 1'b1, 0);
        set_entry(12, reg_imm12(ADDI_W, 12'h040, 0, 11), 1'b0, 11, 32'h40, 1'b1, 0);
        set_entry(13, reg_imm12(ST_W, 12'h008, 11, 1), 1'b1, 1, 32'h1234_5678, 1'b0, 32'h48);
        set_entry(14, reg_imm12(LD_W, 12'h008, 11, 12), 1'b1, 12, 32'h1234_5678, 1'b1, 32'h48);
        set_entry(15, reg_imm12(LD_W, 12'h010, 11, 13), 1'b1, 13, 32'hC0DE_0050, 1'b1, 32'h50);
        set_entry(16, reg_imm12(ST_W, 12'hFFC, 11, 4), 1'b1, 4, 32'hFFFF_FFFF, 1'b0, 32'h3C);
        set_entry(17, reg_imm12(LD_W, 12'hFFC, 11, 14), 1'b1, 14, 32'hFFFF_FFFF, 1'b1, 32'h3C);
        set_entry(18, three_reg(ADD_W, 12, 14, 15), 1'b0, 15, 32'h1234_5677, 1'b1, 0);
        set_entry(19, reg_imm12(ADDI_W, 12'h001, 15, 16), 1'b0, 16, 32'h1234_5678, 1'b1, 0);
    endtask

    task automatic record_result(input string name, input int errs);
        if (errs == 0) begin
            pass_count++;
            $display("test %s: passed", name);
        end else begin
            fail_count++;
            $display("test %s: failed with %0d errors", name, errs);
        end
    endtask

    task automatic check_reset();
        int errs;
        errs = 0;
        if (ex_finish !== 1'b0 || debug_wb_valid !== 1'b0) begin
            $display("FAIL reset ex_finish/debug_wb_valid: got %h/%h, expected 0/0",
                     ex_finish, debug_wb_valid);
            errs++;
        end
        if (daccess_ren !== 4'h0 || daccess_wen !== 4'h0) begin
            $display("FAIL reset daccess_ren/daccess_wen: got %h/%h, expected 0/0",
                     daccess_ren, daccess_wen);
            errs++;
        end
        record_result("reset", errs);
    endtask

    task automatic check_writeback();
        int    n;
        int    errs;
        word_t exp_pc;
        test_t t;
        errs = 0;
        if (idx_q.size() == 0) begin
            $display("Write-back at pc %h with no instruction outstanding", debug_wb_pc);
            fail_count++;
            return;
        end
        n      = idx_q.pop_front();
        exp_pc = pc_q.pop_front();
        t      = tests[n];
        if (ex_finish !== 1'b1) begin
            $display("FAIL test %0d ex_finish: got %h, expected 1", n, ex_finish);
            errs++;
        end
        if (debug_wb_pc !== exp_pc) begin
            $display("FAIL test %0d debug_wb_pc: got %h, expected %h", n, debug_wb_pc, exp_pc);
            errs++;
        end
        if (debug_wb_ena !== {4{t.we}}) begin
            $display("FAIL test %0d debug_wb_ena: got %h, expected %h", n, debug_wb_ena,
                     {4{t.we}});
            errs++;
        end
        if (t.we && debug_wb_reg !== t.rd) begin
            $display("FAIL test %0d debug_wb_reg: got %h, expected %h", n, debug_wb_reg, t.rd);
            errs++;
        end
        if (t.we && debug_wb_value !== t.value) begin
            $display("FAIL test %0d debug_wb_value: got %h, expected %h", n, debug_wb_value,
                     t.value);
            errs++;
        end
        if (t.is_mem) begin
            errs += mem_errs;    // Address mismatches seen by the memory model
            mem_errs = 0;
        end
        retired++;
        record_result($sformatf("%0d", n), errs);
    endtask

    task automatic issue(input int n);
        ex_flag   = 1'b1;
        ex_inst   = tests[n].inst;
        exp_addr  = tests[n].addr;
        exp_wdata = tests[n].value;
        idx_q.push_back(n);
        pc_q.push_back(RESET_PC + 32'(4 * n));
        issued++;
        @(posedge cpu_clk);
        #2;
        ex_flag = 1'b0;
    endtask

    task automatic wait_for_retire();
        while (retired != issued) begin
            @(posedge cpu_clk);
            #2;
        end
    endtask

    initial begin
        cpu_clk = 1'b0;
        forever #10 cpu_clk = ~cpu_clk;
    end

    // Scoreboard samples 1 ns after the edge, the driver acts at 2 ns
    initial begin
        forever begin
            @(posedge cpu_clk);
            #1;
            if (ex_finish === 1'b1) begin
                finish_count++;
            end
            if (debug_wb_valid === 1'b1) begin
                check_writeback();
            end
        end
    end

    initial begin : memory_model
        int   wait_cnt;
        logic busy;
        logic is_read;
        busy          = 1'b0;
        daccess_valid = 1'b0;
        daccess_wresp = 1'b0;
        daccess_rdata = '0;
        for (int i = 0; i < 64; i++) begin
            mem[i] = 32'hC0DE_0000 | word_t'(i * 4);
        end
        forever begin
            @(posedge cpu_clk);
            #2;
            daccess_valid = 1'b0;
            daccess_wresp = 1'b0;
            if (busy) begin
                if (wait_cnt == 0) begin
                    busy = 1'b0;
                    if (is_read) begin
                        daccess_rdata = mem[daccess_addr[7:2]];
                        daccess_valid = 1'b1;
                    end else begin
                        mem[daccess_addr[7:2]] = daccess_wdata;
                        daccess_wresp = 1'b1;
                    end
                end else begin
                    wait_cnt--;
                end
            end else if (daccess_ren != 4'h0 || daccess_wen != 4'h0) begin
                busy     = 1'b1;
                is_read  = (daccess_ren != 4'h0);
                wait_cnt = {$random(seed)} % 4;    // Response after 1 to 4 cycles
                if (daccess_addr !== exp_addr) begin
                    $display("FAIL daccess_addr: got %h, expected %h", daccess_addr, exp_addr);
                    mem_errs++;
                end
                if (!is_read && daccess_wdata !== exp_wdata) begin
                    $display("FAIL daccess_wdata: got %h, expected %h", daccess_wdata,
                             exp_wdata);
                    mem_errs++;
                end
            end
        end
    end

    initial begin : watchdog
        while (cycles < CYCLE_LIMIT) begin
            @(posedge cpu_clk);
            cycles++;
        end
        $display("Timeout after %0d cycles with %0d of %0d instructions retired",
                 cycles, retired, NUM_TESTS);
        $display("** FAIL **");
        $finish;
    end

    initial begin
        cpu_rstn  = 1'b0;
        ex_flag   = 1'b0;
        ex_inst   = '0;
        exp_addr  = '0;
        exp_wdata = '0;
        load_table();
        repeat (4) @(posedge cpu_clk);
        #2;
        cpu_rstn = 1'b1;
        @(posedge cpu_clk);
        #2;
        check_reset();
        for (int i = 0; i < NUM_TESTS; i++) begin
            if (tests[i].is_mem) begin
                wait_for_retire();    // Memory ops go into an empty pipeline
            end
            issue(i);
            if (tests[i].is_mem) begin
                wait_for_retire();
            end
        end
        wait_for_retire();
        repeat (5) @(posedge cpu_clk);    // Room for a stray ex_finish
        #2;
        if (finish_count != NUM_TESTS) begin
            $display("ex_finish pulsed %0d times for %0d instructions",
                     finish_count, NUM_TESTS);
            fail_count++;
        end
        $display("Summary: %0d tests passed, %0d failed", pass_count, fail_count);
        if (fail_count == 0 && retired == NUM_TESTS) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== bench/cpu_assertions.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpu_assertions (
    input logic           cpu_clk,
    input logic           cpu_rstn,
    input logic           stall,
    input logic           ex_finish,
    input logic [3:0]     daccess_ren,
    input logic [3:0]     daccess_wen,
    input cpu_pkg::word_t daccess_addr,
    input cpu_pkg::word_t daccess_wdata,
    input logic           daccess_valid,
    input logic           daccess_wresp,
    input logic           debug_wb_valid,
    input logic [3:0]     debug_wb_ena
);

    logic pending;

    assign pending = (daccess_ren != 4'h0) || (daccess_wen != 4'h0);

    no_dual_access: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
        !((daccess_ren != 4'h0) && (daccess_wen != 4'h0)))
        else $error("daccess read and write enables set together");

    // Request held until its response cycle
    stable_request: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
        (pending && !daccess_valid && !daccess_wresp) |=>
        (pending && $stable(daccess_addr) && $stable(daccess_wdata)))
        else $error("daccess request changed before its response");

    ena_needs_valid: assert property (@(posedge cpu_clk) disable iff (!cpu_rstn)
        (debug_wb_ena != 4'h0) |-> debug_wb_valid)
        else $error("debug_wb_ena set without debug_wb_valid");

    reset_values: assert property (@(posedge cpu_clk)
        $rose(cpu_rstn) |-> (!ex_finish && !debug_wb_valid && (debug_wb_ena == 4'h0) &&
                             !pending && !stall))
        else $error("outputs not at reset values after reset release");

endmodule

bind cpu_core cpu_assertions u_cpu_assertions (
    .cpu_clk       (cpu_clk),
    .cpu_rstn      (cpu_rstn),
    .stall         (stall),
    .ex_finish     (ex_finish),
    .daccess_ren   (daccess_ren),
    .daccess_wen   (daccess_wen),
    .daccess_addr  (daccess_addr),
    .daccess_wdata (daccess_wdata),
    .daccess_valid (daccess_valid),
    .daccess_wresp (daccess_wresp),
    .debug_wb_valid(debug_wb_valid),
    .debug_wb_ena  (debug_wb_ena)
);

`default_nettype wire

// ==== src/cpu_core.sv ====
`default_nettype none
`timescale 1ns/1ps

module cpu_core #(
    parameter cpu_pkg::word_t RESET_PC = 32'h1C00_0000
) (
    input  logic               cpu_clk,
    input  logic               cpu_rstn,
    input  logic               ex_flag,
    input  cpu_pkg::word_t     ex_inst,
    output logic               ex_finish,
    output logic [3:0]         daccess_ren,
    output logic [3:0]         daccess_wen,
    output cpu_pkg::word_t     daccess_addr,
    output cpu_pkg::word_t     daccess_wdata,
    input  logic               daccess_valid,
    input  logic               daccess_wresp,
    input  cpu_pkg::word_t     daccess_rdata,
    output logic               debug_wb_valid,
    output cpu_pkg::word_t     debug_wb_pc,
    output logic [3:0]         debug_wb_ena,
    output cpu_pkg::reg_addr_t debug_wb_reg,
    output cpu_pkg::word_t     debug_wb_value
);
    import cpu_pkg::*;

    typedef struct packed {
        word_t pc;
        word_t inst;
    } id_stage_t;

    typedef struct packed {
        word_t     pc;
        ctrl_t     ctrl;
        reg_addr_t rd;
        word_t     op_a;
        word_t     op_b;    // Also the store data
        word_t     imm;
    } ex_stage_t;

    typedef struct packed {
        word_t     pc;
        ctrl_t     ctrl;
        reg_addr_t rd;
        word_t     result;
        word_t     store;
    } mem_stage_t;

    typedef struct packed {
        word_t     pc;
        ctrl_t     ctrl;
        reg_addr_t rd;
        word_t     result;
    } wb_stage_t;

    typedef struct packed {
        logic      we;
        reg_addr_t rd;
        word_t     data;
    } fwd_src_t;

    logic       id_valid, ex_valid, mem_valid, wb_valid;
    id_stage_t  id_q;
    ex_stage_t  ex_q;
    mem_stage_t mem_q;
    wb_stage_t  wb_q;

    logic       stall;
    logic       accept;
    word_t      fetch_pc;
    ctrl_t      dec_ctrl;
    reg_addr_t  dec_rj, dec_rk, dec_rd;
    word_t      dec_imm;
    logic       dec_uses_rk;
    word_t      rf_rdata1, rf_rdata2;
    word_t      id_op_a, id_op_b;
    word_t      ex_result, mem_rdata, wb_wdata;
    fwd_src_t   ex_fwd, mem_fwd, wb_fwd;
    mem_req_t   mem_req;

    // Youngest matching producer wins
    function automatic word_t forward(input reg_addr_t src, input word_t rf_val,
                                     input fwd_src_t ex_s, input fwd_src_t mem_s,
                                     input fwd_src_t wb_s);
        word_t val;
        val = rf_val;
        if (src != '0) begin
            if (ex_s.we && (ex_s.rd == src)) begin
                val = ex_s.data;
            end else if (mem_s.we && (mem_s.rd == src)) begin
                val = mem_s.data;
            end else if (wb_s.we && (wb_s.rd == src)) begin
                val = wb_s.data;
            end
        end
        return val;
    endfunction

    assign accept = ex_flag && !stall;    // ex_flag ignored while stalled

    pc_counter #(.RESET_PC(RESET_PC)) u_pc_counter (
        .cpu_clk (cpu_clk),
        .cpu_rstn(cpu_rstn),
        .advance (accept),
        .pc      (fetch_pc)
    );

    inst_decoder u_inst_decoder (
        .inst   (id_q.inst),
        .ctrl   (dec_ctrl),
        .rj     (dec_rj),
        .rk     (dec_rk),
        .rd     (dec_rd),
        .imm    (dec_imm),
        .uses_rk(dec_uses_rk)
    );

    reg_file u_reg_file (
        .cpu_clk (cpu_clk),
        .cpu_rstn(cpu_rstn),
        .raddr1  (dec_rj),
        .raddr2  (dec_rk),
        .rdata1  (rf_rdata1),
        .rdata2  (rf_rdata2),
        .we      (wb_fwd.we),
        .waddr   (wb_q.rd),
        .wdata   (wb_wdata)
    );

    assign ex_fwd  = '{we: ex_valid && ex_q.ctrl.rf_we, rd: ex_q.rd, data: ex_result};
    assign mem_fwd = '{we: mem_valid && mem_q.ctrl.rf_we, rd: mem_q.rd, data: mem_q.result};
    assign wb_fwd  = '{we: wb_valid && wb_q.ctrl.rf_we, rd: wb_q.rd, data: wb_wdata};

    assign id_op_a = forward(dec_rj, rf_rdata1, ex_fwd, mem_fwd, wb_fwd);
    assign id_op_b = dec_uses_rk ? forward(dec_rk, rf_rdata2, ex_fwd, mem_fwd, wb_fwd)
                                 : rf_rdata2;

    exec_unit u_exec_unit (
        .ctrl  (ex_q.ctrl),
        .op_a  (ex_q.op_a),
        .op_b  (ex_q.op_b),
        .imm   (ex_q.imm),
        .result(ex_result)
    );

    assign mem_req = '{rd: mem_q.ctrl.mem_rd, wr: mem_q.ctrl.mem_wr,
                       addr: mem_q.result, wdata: mem_q.store};

    mem_access_ctrl u_mem_access_ctrl (
        .cpu_clk      (cpu_clk),
        .cpu_rstn     (cpu_rstn),
        .req          (mem_req),
        .req_valid    (mem_valid),
        .stall        (stall),
        .rdata        (mem_rdata),
        .daccess_ren  (daccess_ren),
        .daccess_wen  (daccess_wen),
        .daccess_addr (daccess_addr),
        .daccess_wdata(daccess_wdata),
        .daccess_valid(daccess_valid),
        .daccess_wresp(daccess_wresp),
        .daccess_rdata(daccess_rdata)
    );

    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            id_valid  <= 1'b0;
            ex_valid  <= 1'b0;
            mem_valid <= 1'b0;
            wb_valid  <= 1'b0;
        end else begin
            if (!stall) begin
                id_valid  <= ex_flag;
                ex_valid  <= id_valid;
                mem_valid <= ex_valid;
            end
            wb_valid <= mem_valid && !stall;    // Bubble while memory waits
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (!stall) begin
            id_q  <= '{pc: fetch_pc, inst: ex_inst};
            ex_q  <= '{pc: id_q.pc, ctrl: dec_ctrl, rd: dec_rd,
                       op_a: id_op_a, op_b: id_op_b, imm: dec_imm};
            mem_q <= '{pc: ex_q.pc, ctrl: ex_q.ctrl, rd: ex_q.rd,
                       result: ex_result, store: ex_q.op_b};
            wb_q  <= '{pc: mem_q.pc, ctrl: mem_q.ctrl, rd: mem_q.rd, result: mem_q.result};
        end
    end

    // Load data comes from the controller's capture register
    assign wb_wdata = (wb_q.ctrl.wd_sel == WD_RAM) ? mem_rdata : wb_q.result;

    assign ex_finish      = wb_valid;
    assign debug_wb_valid = wb_valid;
    assign debug_wb_pc    = wb_q.pc;
    assign debug_wb_ena   = {4{wb_fwd.we}};
    assign debug_wb_reg   = wb_q.rd;
    assign debug_wb_value = wb_wdata;

endmodule

`default_nettype wire

// ==== src/mem_access_ctrl.sv ====
`default_nettype none
`timescale 1ns/1ps

module mem_access_ctrl (
    input  logic              cpu_clk,
    input  logic              cpu_rstn,
    input  cpu_pkg::mem_req_t req,
    input  logic              req_valid,
    output logic              stall,
    output cpu_pkg::word_t    rdata,
    output logic [3:0]        daccess_ren,
    output logic [3:0]        daccess_wen,
    output cpu_pkg::word_t    daccess_addr,
    output cpu_pkg::word_t    daccess_wdata,
    input  logic              daccess_valid,
    input  logic              daccess_wresp,
    input  cpu_pkg::word_t    daccess_rdata
);
    import cpu_pkg::*;

    mem_state_e state;
    mem_req_t   req_q;
    logic       start;
    logic       done;

    assign start = (state == MEM_IDLE) && req_valid && (req.rd || req.wr);
    assign done  = ((state == MEM_READ) && daccess_valid) ||
                   ((state == MEM_WRITE) && daccess_wresp);

    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            state <= MEM_IDLE;
        end else begin
            case (state)
                MEM_IDLE:  if (start) state <= req.rd ? MEM_READ : MEM_WRITE;
                MEM_READ,
                MEM_WRITE: if (done) state <= MEM_IDLE;
                default:   state <= MEM_IDLE;
            endcase
        end
    end

    always_ff @(posedge cpu_clk) begin
        if (start) begin
            req_q <= req;    // Held stable until the response
        end
        if ((state == MEM_READ) && daccess_valid) begin
            rdata <= daccess_rdata;
        end
    end

    // Also high in the cycle a new request is seen
    assign stall = start || ((state != MEM_IDLE) && !done);

    assign daccess_ren   = (state == MEM_READ) ? 4'hF : 4'h0;
    assign daccess_wen   = (state == MEM_WRITE) ? 4'hF : 4'h0;
    assign daccess_addr  = req_q.addr;
    assign daccess_wdata = req_q.wdata;

endmodule

`default_nettype wire

// ==== src/exec_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module exec_unit (
    input  cpu_pkg::ctrl_t ctrl,
    input  cpu_pkg::word_t op_a,
    input  cpu_pkg::word_t op_b,
    input  cpu_pkg::word_t imm,
    output cpu_pkg::word_t result
);
    import cpu_pkg::*;

    word_t src_b;
    logic  less;

    assign src_b = ctrl.src_b_imm ? imm : op_b;
    assign less  = $signed(op_a) < $signed(src_b);

    // Loads and stores take the ALU_ADD path for rj + si12
    always_comb begin
        case (ctrl.alu_op)
            ALU_ADD: result = op_a + src_b;
            ALU_SUB: result = op_a - src_b;
            ALU_SLT: result = {{(XLEN-1){1'b0}}, less};
            ALU_AND: result = op_a & src_b;
            ALU_OR:  result = op_a | src_b;
            ALU_XOR: result = op_a ^ src_b;
            ALU_LUI: result = imm;    // Already shifted up by the decoder
            default: result = '0;
        endcase
    end

endmodule

`default_nettype wire

// ==== src/reg_file.sv ====
`default_nettype none
`timescale 1ns/1ps

module reg_file (
    input  logic               cpu_clk,
    input  logic               cpu_rstn,
    input  cpu_pkg::reg_addr_t raddr1,
    input  cpu_pkg::reg_addr_t raddr2,
    output cpu_pkg::word_t     rdata1,
    output cpu_pkg::word_t     rdata2,
    input  logic               we,
    input  cpu_pkg::reg_addr_t waddr,
    input  cpu_pkg::word_t     wdata
);
    import cpu_pkg::*;

    localparam int NUM_REGS = 1 << REG_ADDR_W;

    word_t regs [NUM_REGS];

    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            for (int i = 0; i < NUM_REGS; i++) begin
                regs[i] <= '0;
            end
        end else if (we && (waddr != '0)) begin    // r0 stays zero
            regs[waddr] <= wdata;
        end
    end

    assign rdata1 = (raddr1 == '0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == '0) ? '0 : regs[raddr2];

endmodule

`default_nettype wire

// ==== src/inst_decoder.sv ====
`default_nettype none
`timescale 1ns/1ps

module inst_decoder (
    input  cpu_pkg::word_t     inst,
    output cpu_pkg::ctrl_t     ctrl,
    output cpu_pkg::reg_addr_t rj,
    output cpu_pkg::reg_addr_t rk,
    output cpu_pkg::reg_addr_t rd,
    output cpu_pkg::word_t     imm,
    output logic               uses_rk
);
    import cpu_pkg::*;

    logic [16:0] op_r;
    logic [9:0]  op_i12;
    logic [6:0]  op_i20;
    word_t       si12_ext;
    word_t       si20_up;

    assign op_r   = inst[XLEN-1:OP_R_LSB];
    assign op_i12 = inst[XLEN-1:OP_I12_LSB];
    assign op_i20 = inst[XLEN-1:OP_I20_LSB];

    assign si12_ext = {{(XLEN-SI12_W){inst[SI12_LSB+SI12_W-1]}}, inst[SI12_LSB +: SI12_W]};
    assign si20_up  = {inst[SI20_LSB +: SI20_W], {(XLEN-SI20_W){1'b0}}};

    assign rj = inst[RJ_LSB +: REG_ADDR_W];
    assign rd = inst[RD_LSB +: REG_ADDR_W];

    always_comb begin
        ctrl    = '0;          // No-op unless a code matches
        imm     = si12_ext;
        uses_rk = 1'b0;
        rk      = inst[RK_LSB +: REG_ADDR_W];
        if (op_r inside {OP_ADD_W, OP_SUB_W, OP_SLT, OP_AND, OP_OR, OP_XOR}) begin
            ctrl.rf_we = 1'b1;
            uses_rk    = 1'b1;
            case (op_r)
                OP_SUB_W: ctrl.alu_op = ALU_SUB;
                OP_SLT:   ctrl.alu_op = ALU_SLT;
                OP_AND:   ctrl.alu_op = ALU_AND;
                OP_OR:    ctrl.alu_op = ALU_OR;
                OP_XOR:   ctrl.alu_op = ALU_XOR;
                default:  ctrl.alu_op = ALU_ADD;
            endcase
        end else if (op_i12 == OP_ADDI_W || op_i12 == OP_LD_W) begin
            ctrl.src_b_imm = 1'b1;
            ctrl.rf_we     = 1'b1;
            if (op_i12 == OP_LD_W) begin
                ctrl.wd_sel = WD_RAM;
                ctrl.mem_rd = 1'b1;
            end
        end else if (op_i12 == OP_ST_W) begin
            ctrl.src_b_imm = 1'b1;
            ctrl.mem_wr    = 1'b1;
            rk             = rd;    // Store data register sits in the rd field
            uses_rk        = 1'b1;
        end else if (op_i20 == OP_LU12I_W) begin
            ctrl.alu_op    = ALU_LUI;
            ctrl.src_b_imm = 1'b1;
            ctrl.rf_we     = 1'b1;
            imm            = si20_up;
        end
    end

endmodule

`default_nettype wire

// ==== src/pc_counter.sv ====
`default_nettype none
`timescale 1ns/1ps

module pc_counter #(
    parameter cpu_pkg::word_t RESET_PC = 32'h1C00_0000
) (
    input  logic           cpu_clk,
    input  logic           cpu_rstn,
    input  logic           advance,
    output cpu_pkg::word_t pc
);

    always_ff @(posedge cpu_clk or negedge cpu_rstn) begin
        if (!cpu_rstn) begin
            pc <= RESET_PC;
        end else if (advance) begin
            pc <= pc + 32'd4;    // One instruction word
        end
    end

endmodule

`default_nettype wire

// ==== src/cpu_pkg.sv ====
`default_nettype none

package cpu_pkg;

    localparam int XLEN       = 32;
    localparam int REG_ADDR_W = 5;

    typedef logic [XLEN-1:0]       word_t;
    typedef logic [REG_ADDR_W-1:0] reg_addr_t;

    // Instruction field positions
    localparam int RD_LSB     = 0;
    localparam int RJ_LSB     = 5;
    localparam int RK_LSB     = 10;
    localparam int SI12_LSB   = 10;
    localparam int SI12_W     = 12;
    localparam int SI20_LSB   = 5;
    localparam int SI20_W     = 20;
    localparam int OP_R_LSB   = 15;    // 3R group opcode in bits 31..15
    localparam int OP_I12_LSB = 22;    // 2RI12 group in bits 31..22
    localparam int OP_I20_LSB = 25;    // 1RI20 group in bits 31..25

    // Opcode values
    localparam logic [16:0] OP_ADD_W   = 17'h00020;
    localparam logic [16:0] OP_SUB_W   = 17'h00022;
    localparam logic [16:0] OP_SLT     = 17'h00024;
    localparam logic [16:0] OP_AND     = 17'h00029;
    localparam logic [16:0] OP_OR      = 17'h0002A;
    localparam logic [16:0] OP_XOR     = 17'h0002B;
    localparam logic [9:0]  OP_ADDI_W  = 10'h00A;
    localparam logic [9:0]  OP_LD_W    = 10'h0A2;
    localparam logic [9:0]  OP_ST_W    = 10'h0A6;
    localparam logic [6:0]  OP_LU12I_W = 7'h0A;

    typedef enum logic [2:0] {
        ALU_ADD, ALU_SUB, ALU_SLT, ALU_AND, ALU_OR, ALU_XOR, ALU_LUI
    } alu_op_e;

    typedef enum logic {
        WD_ALU,
        WD_RAM
    } wd_sel_e;

    typedef enum logic [1:0] {
        MEM_IDLE,
        MEM_READ,
        MEM_WRITE
    } mem_state_e;

    typedef struct packed {
        alu_op_e alu_op;
        logic    src_b_imm;    // Operand B from the immediate
        logic    rf_we;
        wd_sel_e wd_sel;
        logic    mem_rd;
        logic    mem_wr;
    } ctrl_t;

    typedef struct packed {
        logic  rd;
        logic  wr;
        word_t addr;
        word_t wdata;
    } mem_req_t;

endpackage

`default_nettype wire
